// File: rtl/bpu_pkg.sv
/*
 * Branch prediction package
 * Table sizes, address and history vector types, the decode and
 * branch kind encodings, and the records passed between fetch-time
 * prediction and resolve-time feedback.
 */
package bpu_pkg;

	// -------------------------------------------------------------------
	// Table sizes
	// -------------------------------------------------------------------
	localparam int BTB_IDX_W  = 6;
	localparam int BTB_DEPTH  = 1 << BTB_IDX_W;
	localparam int BTB_TAG_W  = 30 - BTB_IDX_W;
	localparam int LPHR_IDX_W = 4;
	localparam int LPHR_DEPTH = 1 << LPHR_IDX_W;
	localparam int LPHR_W     = 4;
	localparam int PHT_DEPTH  = 1 << LPHR_W;
	localparam int RAS_DEPTH  = 8;
	localparam int RAS_PTR_W  = $clog2(RAS_DEPTH);

	typedef logic [31:0]           addr_t;
	typedef logic [29:0]           word_pc_t;
	typedef logic [BTB_IDX_W-1:0]  btb_idx_t;
	typedef logic [BTB_TAG_W-1:0]  btb_tag_t;
	typedef logic [LPHR_W-1:0]     lphr_t;
	typedef logic [LPHR_IDX_W-1:0] lphr_idx_t;
	typedef logic [1:0]            ctr_t;
	typedef logic [RAS_PTR_W-1:0]  ras_ptr_t;
	typedef logic [RAS_PTR_W:0]    ras_cnt_t;

	// Weakly not taken
	localparam ctr_t CTR_INIT = 2'b01;

	// -------------------------------------------------------------------
	// Encodings
	// -------------------------------------------------------------------
	typedef enum logic [1:0] {INVALID, IMMEDIATE, INDIRECT, CONDITION} branch_type_t;

	typedef enum logic [2:0] {EQL, NEQ, LSS, GER, LEQ, GEQ, LTU, GEU} cmp_type_t;

	typedef enum logic [1:0] {PC_RELATIVE, ABSOLUTE, CALL, RETURN} br_kind_t;

	typedef struct packed {
		logic [25:0]  inst25_0;
		branch_type_t branch_type;
		cmp_type_t    cmp_type;
		logic         branch_link;
		logic         valid;
	} decode_info_t;

	// Carried down the pipeline with each fetched instruction
	typedef struct packed {
		word_pc_t  npc;
		lphr_t     lphr;
		lphr_idx_t lphr_index;
	} bpu_predict_t;

	typedef struct packed {
		logic      flush;
		logic      br_taken;
		word_pc_t  pc;
		word_pc_t  br_target;
		br_kind_t  br_type;
		logic      btb_update;
		logic      bht_update;
		logic      lpht_update;
		lphr_t     lphr;
		lphr_idx_t lphr_index;
	} bpu_update_t;

endpackage

// File: rtl/bpu_ras.sv
/*
 * Return address stack
 * Circular stack of word addresses. A push on a full stack drops the
 * oldest entry, a pop on an empty stack is ignored.
 */
`timescale 1ns/1ps

module bpu_ras
	import bpu_pkg::*;
(
	input  logic     clk,
	input  logic     reset_i,
	input  logic     push_i,
	input  word_pc_t push_addr_i,
	input  logic     pop_i,
	output word_pc_t top_o
);

	word_pc_t stack [RAS_DEPTH];
	ras_ptr_t ptr;
	ras_ptr_t ptr_pop;
	ras_ptr_t ptr_nxt;
	ras_cnt_t cnt;
	ras_cnt_t cnt_pop;
	ras_cnt_t cnt_nxt;
	logic     do_pop;

	// Pop is applied first, the push then lands on the new top
	assign do_pop  = pop_i && (cnt != '0);
	assign ptr_pop = do_pop ? ptr - 1'b1 : ptr;
	assign cnt_pop = do_pop ? cnt - 1'b1 : cnt;
	assign ptr_nxt = push_i ? ptr_pop + 1'b1 : ptr_pop;
	assign cnt_nxt = (push_i && (cnt_pop != RAS_DEPTH)) ? cnt_pop + 1'b1 : cnt_pop;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ptr <= '0;
			cnt <= '0;
		end else begin
			ptr <= ptr_nxt;
			cnt <= cnt_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (push_i) begin
			stack[ptr_nxt] <= push_addr_i;
		end
	end

	assign top_o = stack[ptr];

endmodule

// File: rtl/bpu_predict.sv
/*
 * Fetch-time next PC prediction
 * Direct-mapped BTB with target and branch kind, local history
 * registers selecting a two-bit pattern counter, and the return
 * address stack for returns. Tables train from the resolve update.
 */
`timescale 1ns/1ps

module bpu_predict
	import bpu_pkg::*;
(
	input  logic         clk,
	input  logic         reset_i,
	input  addr_t        fetch_pc_i,
	input  logic         fetch_valid_i,
	input  word_pc_t     ras_top_i,
	output logic         ras_pop_o,
	input  bpu_update_t  update_i,
	output bpu_predict_t predict_o
);

	logic     btb_valid  [BTB_DEPTH];
	btb_tag_t btb_tag    [BTB_DEPTH];
	word_pc_t btb_target [BTB_DEPTH];
	br_kind_t btb_kind   [BTB_DEPTH];
	lphr_t    lphr_tbl   [LPHR_DEPTH];
	ctr_t     pht        [PHT_DEPTH];

	word_pc_t  fetch_wpc;
	btb_idx_t  rd_idx;
	logic      btb_hit;
	lphr_idx_t hist_idx;
	lphr_t     hist;
	ctr_t      ctr;
	word_pc_t  npc;

	btb_idx_t  wr_idx;
	ctr_t      ctr_old;
	ctr_t      ctr_new;

	// -------------------------------------------------------------------
	// Lookup
	// -------------------------------------------------------------------
	assign fetch_wpc = fetch_pc_i[31:2];
	assign rd_idx    = fetch_wpc[BTB_IDX_W-1:0];
	assign btb_hit   = btb_valid[rd_idx] && (btb_tag[rd_idx] == fetch_wpc[29:BTB_IDX_W]);
	assign hist_idx  = fetch_wpc[LPHR_IDX_W-1:0];
	assign hist      = lphr_tbl[hist_idx];
	assign ctr       = pht[hist];

	always_comb begin
		npc       = fetch_wpc + 30'd1;
		ras_pop_o = 1'b0;
		if (btb_hit) begin
			case (btb_kind[rd_idx])
				ABSOLUTE, CALL: npc = btb_target[rd_idx];
				RETURN: begin
					npc       = ras_top_i;
					ras_pop_o = fetch_valid_i;
				end
				PC_RELATIVE: begin
					// Counter high bit means predict taken
					if (ctr[1]) begin
						npc = btb_target[rd_idx];
					end
				end
				default: npc = fetch_wpc + 30'd1;
			endcase
		end
	end

	assign predict_o.npc        = npc;
	assign predict_o.lphr       = hist;
	assign predict_o.lphr_index = hist_idx;

	// -------------------------------------------------------------------
	// Training
	// -------------------------------------------------------------------
	assign wr_idx  = update_i.pc[BTB_IDX_W-1:0];
	assign ctr_old = pht[update_i.lphr];

	always_comb begin
		ctr_new = ctr_old;
		if (update_i.br_taken && (ctr_old != 2'b11)) begin
			ctr_new = ctr_old + 2'b01;
		end else if (!update_i.br_taken && (ctr_old != 2'b00)) begin
			ctr_new = ctr_old - 2'b01;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < BTB_DEPTH; i++) begin
				btb_valid[i] <= 1'b0;
			end
			for (int i = 0; i < LPHR_DEPTH; i++) begin
				lphr_tbl[i] <= '0;
			end
			for (int i = 0; i < PHT_DEPTH; i++) begin
				pht[i] <= CTR_INIT;
			end
		end else begin
			if (update_i.btb_update) begin
				btb_valid[wr_idx] <= 1'b1;
			end
			if (update_i.lpht_update) begin
				lphr_tbl[update_i.lphr_index] <= {update_i.lphr[LPHR_W-2:0], update_i.br_taken};
			end
			if (update_i.bht_update) begin
				pht[update_i.lphr] <= ctr_new;
			end
		end
	end

	// BTB payload, qualified by the valid bits above
	always_ff @(posedge clk) begin
		if (update_i.btb_update) begin
			btb_tag[wr_idx]    <= update_i.pc[29:BTB_IDX_W];
			btb_target[wr_idx] <= update_i.br_target;
			btb_kind[wr_idx]   <= update_i.br_type;
		end
	end

endmodule

// File: rtl/bpf.sv
/*
 * Branch resolve feedback
 * Computes the real target and taken outcome of a decoded branch,
 * classifies it for the BTB and raises flush on a wrong next PC.
 * Drives the update record that trains the predictor tables.
 */
`timescale 1ns/1ps

module bpf
	import bpu_pkg::*;
(
	input  addr_t        pc_i,
	input  addr_t        rj_i,
	input  addr_t        rd_i,
	input  decode_info_t decode_i,
	input  bpu_predict_t predict_i,
	output bpu_update_t  update_o,
	output addr_t        target_o
);

	logic [25:0] offs;
	logic [4:0]  rj_index;
	logic [4:0]  rd_index;
	addr_t       offs_26;
	addr_t       offs_16;
	logic        taken;
	logic        flush;
	br_kind_t    kind;

	assign offs     = decode_i.inst25_0;
	assign rj_index = offs[9:5];
	assign rd_index = offs[4:0];
	// Both offsets are word offsets, sign taken from bit 25
	assign offs_26  = {{6{offs[25]}}, offs};
	assign offs_16  = {{16{offs[25]}}, offs[25:10]};

	always_comb begin
		case (decode_i.branch_type)
			IMMEDIATE: target_o = pc_i + (offs_26 << 2);
			INDIRECT:  target_o = rj_i + (offs_16 << 2);
			CONDITION: target_o = pc_i + (offs_16 << 2);
			default:   target_o = pc_i + 32'd4;
		endcase
	end

	always_comb begin
		if (decode_i.branch_type == CONDITION) begin
			case (decode_i.cmp_type)
				EQL:     taken = rj_i == rd_i;
				NEQ:     taken = rj_i != rd_i;
				LSS:     taken = $signed(rj_i) < $signed(rd_i);
				GER:     taken = $signed(rj_i) > $signed(rd_i);
				LEQ:     taken = $signed(rj_i) <= $signed(rd_i);
				GEQ:     taken = $signed(rj_i) >= $signed(rd_i);
				LTU:     taken = rj_i < rd_i;
				GEU:     taken = rj_i >= rd_i;
				default: taken = 1'b0;
			endcase
		end else begin
			taken = decode_i.branch_type != INVALID;
		end
	end

	// ra is r1, so jirl with rd=1 is a call and jirl r1 with no offset a return
	always_comb begin
		if (decode_i.branch_link || (decode_i.branch_type == INDIRECT && rd_index == 5'd1)) begin
			kind = CALL;
		end else if (decode_i.branch_type == INDIRECT && rj_index == 5'd1 && offs_16 == '0) begin
			kind = RETURN;
		end else if (decode_i.branch_type == IMMEDIATE || decode_i.branch_type == INDIRECT) begin
			kind = ABSOLUTE;
		end else begin
			kind = PC_RELATIVE;
		end
	end

	assign flush = (predict_i.npc != target_o[31:2]) && decode_i.valid;

	// -------------------------------------------------------------------
	// Update record
	// -------------------------------------------------------------------
	assign update_o.flush       = flush;
	assign update_o.br_taken    = taken;
	assign update_o.pc          = pc_i[31:2];
	assign update_o.br_target   = target_o[31:2];
	assign update_o.br_type     = kind;
	assign update_o.btb_update  = flush;
	assign update_o.bht_update  = decode_i.valid;
	assign update_o.lpht_update = decode_i.valid;
	assign update_o.lphr        = predict_i.lphr;
	assign update_o.lphr_index  = predict_i.lphr_index;

endmodule

// File: rtl/bpu_top.sv
/*
 * Branch prediction unit
 * Fetch-side predictor with its return address stack, and the
 * resolve-side feedback block that trains both.
 */
`timescale 1ns/1ps

module bpu_top
	import bpu_pkg::*;
(
	input  logic         clk,
	input  logic         reset_i,
	input  addr_t        fetch_pc_i,
	input  logic         fetch_valid_i,
	output bpu_predict_t predict_o,
	input  addr_t        res_pc_i,
	input  addr_t        rj_i,
	input  addr_t        rd_i,
	input  decode_info_t decode_i,
	input  bpu_predict_t res_predict_i,
	output addr_t        target_o,
	output logic         flush_o
);

	bpu_update_t update;
	word_pc_t    ras_top;
	logic        ras_pop;
	logic        ras_push;
	word_pc_t    ras_push_addr;

	// Calls push their link address, one word past the call
	assign ras_push      = update.lpht_update && (update.br_type == CALL);
	assign ras_push_addr = update.pc + 30'd1;
	assign flush_o       = update.flush;

	bpu_predict bpu_predict_i (
		.clk          (clk),
		.reset_i      (reset_i),
		.fetch_pc_i   (fetch_pc_i),
		.fetch_valid_i(fetch_valid_i),
		.ras_top_i    (ras_top),
		.ras_pop_o    (ras_pop),
		.update_i     (update),
		.predict_o    (predict_o)
	);

	bpu_ras bpu_ras_i (
		.clk        (clk),
		.reset_i    (reset_i),
		.push_i     (ras_push),
		.push_addr_i(ras_push_addr),
		.pop_i      (ras_pop),
		.top_o      (ras_top)
	);

	bpf bpf_i (
		.pc_i     (res_pc_i),
		.rj_i     (rj_i),
		.rd_i     (rd_i),
		.decode_i (decode_i),
		.predict_i(res_predict_i),
		.update_o (update),
		.target_o (target_o)
	);

endmodule

// File: tests/bpu_chk.sv
/*
 * BPU protocol checker
 * Bound into bpu_top. Watches flush against decode valid, the first
 * prediction after reset and the RAS pop condition.
 */
`timescale 1ns/1ps

module bpu_chk
	import bpu_pkg::*;
(
	input logic     clk,
	input logic     reset_i,
	input logic     decode_valid_i,
	input logic     flush_i,
	input addr_t    fetch_pc_i,
	input logic     fetch_valid_i,
	input word_pc_t npc_i,
	input logic     ras_pop_i
);

	a_flush_needs_valid: assert property (@(posedge clk) disable iff (reset_i)
		!decode_valid_i |-> !flush_i)
		else $error("flush raised while decode is not valid");

	// Tables are empty in the first cycle out of reset
	a_seq_after_reset: assert property (@(posedge clk)
		$fell(reset_i) |-> (npc_i == fetch_pc_i[31:2] + 30'd1))
		else $error("first prediction after reset is not sequential");

	a_pop_needs_fetch: assert property (@(posedge clk) disable iff (reset_i)
		ras_pop_i |-> fetch_valid_i)
		else $error("RAS pop without a valid fetch");

endmodule

bind bpu_top bpu_chk bpu_chk_i (
	.clk           (clk),
	.reset_i       (reset_i),
	.decode_valid_i(decode_i.valid),
	.flush_i       (flush_o),
	.fetch_pc_i    (fetch_pc_i),
	.fetch_valid_i (fetch_valid_i),
	.npc_i         (predict_o.npc),
	.ras_pop_i     (ras_pop)
);

// File: tests/bpu_tb.sv
/*
 * Branch prediction unit testbench
 * Drives fetch lookups and resolve records into the BPU, computes the
 * expected target, taken and flush with its own model, and checks
 * predictions after training of the BTB and the return address stack.
 */
`timescale 1ns/1ps

module bpu_tb
	import bpu_pkg::*;
();

	localparam int RESET_CYCLES = 5;
	localparam int N_BOOT       = 16;
	localparam int N_RANDOM     = 200;
	localparam int N_EDGE       = 48;
	localparam int N_CMP_RAND   = 64;
	localparam int N_DIRECTED   = 12;
	localparam int TIMEOUT_CYCLES =
		2 * (RESET_CYCLES + N_BOOT + N_RANDOM + N_EDGE + N_CMP_RAND + N_DIRECTED);

	typedef struct packed {
		addr_t target;
		logic  taken;
		logic  flush;
	} ref_res_t;

	logic         clk = 1'b0;
	logic         reset_i;
	addr_t        fetch_pc_i;
	logic         fetch_valid_i;
	bpu_predict_t predict_o;
	addr_t        res_pc_i;
	addr_t        rj_i;
	addr_t        rd_i;
	decode_info_t decode_i;
	bpu_predict_t res_predict_i;
	addr_t        target_o;
	logic         flush_o;

	logic         fetch_chk;
	word_pc_t     fetch_exp;
	int           cycle_cnt = 0;

	// Local histories as the resolve stream trains them
	lphr_t        hist_model [LPHR_DEPTH];

	bpu_top bpu_top_i (.*);

	// 40 ns period
	always #20 clk = ~clk;

	// -------------------------------------------------------------------
	// Reference model and checking
	// -------------------------------------------------------------------
	function automatic ref_res_t ref_resolve(addr_t pc, addr_t rj, addr_t rd,
			decode_info_t dec, word_pc_t npc);
		ref_res_t r;
		addr_t    off26;
		addr_t    off16;
		logic     eq;
		logic     slt;
		logic     ult;
		off26 = {{4{dec.inst25_0[25]}}, dec.inst25_0, 2'b00};
		off16 = {{14{dec.inst25_0[25]}}, dec.inst25_0[25:10], 2'b00};
		case (dec.branch_type)
			IMMEDIATE: r.target = pc + off26;
			INDIRECT:  r.target = rj + off16;
			CONDITION: r.target = pc + off16;
			default:   r.target = pc + 32'd4;
		endcase
		// Signed order by flipping the sign bit
		eq  = (rj == rd);
		slt = (rj ^ 32'h8000_0000) < (rd ^ 32'h8000_0000);
		ult = rj < rd;
		if (dec.branch_type == CONDITION) begin
			case (dec.cmp_type)
				EQL: r.taken = eq;
				NEQ: r.taken = !eq;
				LSS: r.taken = slt;
				GER: r.taken = !slt && !eq;
				LEQ: r.taken = slt || eq;
				GEQ: r.taken = !slt;
				LTU: r.taken = ult;
				default: r.taken = !ult;
			endcase
		end else begin
			r.taken = (dec.branch_type != INVALID);
		end
		r.flush = dec.valid && (npc != r.target[31:2]);
		return r;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	always @(posedge clk) begin : compare
		ref_res_t expd;
		if (reset_i) begin
			for (int i = 0; i < LPHR_DEPTH; i++) begin
				hist_model[i] = '0;
			end
		end else begin
			if (fetch_chk) begin
				compare_value("predict_o.npc", {2'b00, predict_o.npc}, {2'b00, fetch_exp});
				compare_value("predict_o.lphr_index", {28'd0, predict_o.lphr_index},
					{28'd0, fetch_pc_i[LPHR_IDX_W+1:2]});
				compare_value("predict_o.lphr", {28'd0, predict_o.lphr},
					{28'd0, hist_model[fetch_pc_i[LPHR_IDX_W+1:2]]});
			end
			if (decode_i.valid) begin
				expd = ref_resolve(res_pc_i, rj_i, rd_i, decode_i, res_predict_i.npc);
				compare_value("target_o", target_o, expd.target);
				compare_value("flush_o", {31'd0, flush_o}, {31'd0, expd.flush});
				compare_value("br_taken", {31'd0, bpu_top_i.update.br_taken},
					{31'd0, expd.taken});
				// Outcome enters the carried history as its newest bit
				hist_model[res_predict_i.lphr_index] =
					{res_predict_i.lphr[LPHR_W-2:0], expd.taken};
			end else begin
				compare_value("flush_o", {31'd0, flush_o}, 32'd0);
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$fatal(1);
		end
	end

	// -------------------------------------------------------------------
	// Stimulus helpers
	// -------------------------------------------------------------------
	function automatic decode_info_t make_decode(branch_type_t bt, cmp_type_t ct,
			logic link, logic [25:0] inst, logic valid);
		decode_info_t d;
		d.inst25_0    = inst;
		d.branch_type = bt;
		d.cmp_type    = ct;
		d.branch_link = link;
		d.valid       = valid;
		return d;
	endfunction

	// Predicted npc is either the real target or one word past it
	task automatic drive_resolve(input addr_t pc, input addr_t rj, input addr_t rd,
			input decode_info_t dec, input logic correct);
		ref_res_t     r;
		bpu_predict_t pred;
		r               = ref_resolve(pc, rj, rd, dec, '0);
		pred.npc        = correct ? r.target[31:2] : r.target[31:2] + 30'd1;
		pred.lphr       = lphr_t'($urandom);
		pred.lphr_index = lphr_idx_t'($urandom);
		@(negedge clk);
		fetch_valid_i = 1'b0;
		fetch_chk     = 1'b0;
		res_pc_i      = pc;
		rj_i          = rj;
		rd_i          = rd;
		decode_i      = dec;
		res_predict_i = pred;
	endtask

	task automatic drive_fetch(input addr_t pc, input word_pc_t exp_npc);
		@(negedge clk);
		decode_i      = '0;
		fetch_pc_i    = pc;
		fetch_valid_i = 1'b1;
		fetch_exp     = exp_npc;
		fetch_chk     = 1'b1;
	endtask

	// -------------------------------------------------------------------
	// Test sequence
	// -------------------------------------------------------------------
	initial begin
		addr_t       edge_a [6];
		addr_t       edge_b [6];
		addr_t       pc;
		void'($urandom(39));
		reset_i       = 1'b1;
		fetch_pc_i    = '0;
		fetch_valid_i = 1'b0;
		res_pc_i      = '0;
		rj_i          = '0;
		rd_i          = '0;
		decode_i      = '0;
		res_predict_i = '0;
		fetch_chk     = 1'b0;
		fetch_exp     = '0;
		edge_a = '{32'h1234_5678, 32'h7fff_ffff, 32'h8000_0000, 32'h0, 32'hffff_ffff, 32'h0};
		edge_b = '{32'h1234_5678, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0, 32'h0};
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;

		// Empty tables give sequential prediction
		for (int i = 0; i < N_BOOT; i++) begin
			pc = $urandom;
			drive_fetch(pc, pc[31:2] + 30'd1);
		end

		for (int i = 0; i < N_RANDOM; i++) begin
			drive_resolve($urandom, $urandom, $urandom,
				make_decode(branch_type_t'($urandom_range(3, 0)),
					cmp_type_t'($urandom_range(7, 0)), ($urandom % 4) == 0,
					26'($urandom), ($urandom % 8) != 0),
				$urandom % 2);
		end

		for (int c = 0; c < 8; c++) begin
			for (int k = 0; k < 6; k++) begin
				drive_resolve($urandom, edge_a[k], edge_b[k],
					make_decode(CONDITION, cmp_type_t'(c), 1'b0, 26'($urandom), 1'b1),
					$urandom % 2);
			end
			for (int k = 0; k < N_CMP_RAND / 8; k++) begin
				drive_resolve($urandom, $urandom, $urandom,
					make_decode(CONDITION, cmp_type_t'(c), 1'b0, 26'($urandom), 1'b1),
					$urandom % 2);
			end
		end

		// Backward jump, 16 words
		drive_resolve(32'h0000_3008, 32'h0, 32'h0,
			make_decode(IMMEDIATE, EQL, 1'b0, 26'h3ff_fff0, 1'b1), 1'b0);
		drive_fetch(32'h0000_3008, 30'(32'h0000_2fc8 >> 2));
		drive_fetch(32'h0000_3008, 30'(32'h0000_2fc8 >> 2));

		// Call then return through r1
		drive_resolve(32'h0000_1100, 32'h0, 32'h0,
			make_decode(IMMEDIATE, EQL, 1'b1, 26'h000_0100, 1'b1), 1'b0);
		drive_resolve(32'h0000_2204, 32'h0000_1104, 32'h0,
			make_decode(INDIRECT, EQL, 1'b0, 26'h000_0020, 1'b1), 1'b0);
		drive_fetch(32'h0000_2204, 30'(32'h0000_1104 >> 2));
		drive_fetch(32'h0000_1100, 30'(32'h0000_1500 >> 2));

		@(negedge clk);
		decode_i      = '0;
		fetch_valid_i = 1'b0;
		fetch_chk     = 1'b0;
		@(posedge clk);
		@(negedge clk);
		$display("Test OK");
		$finish;
	end

endmodule

// File: vlog.f
rtl/bpu_pkg.sv
rtl/bpu_ras.sv
rtl/bpu_predict.sv
rtl/bpf.sv
rtl/bpu_top.sv
tests/bpu_chk.sv
tests/bpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bpu_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
